// ==== fp_pkg.sv ====
package fp_pkg;

    localparam int FRAC_W = 23; // stored fraction.
    localparam int MANT_W = 24; // fraction plus hidden bit.
    localparam int EXP_BIAS = 127;
    localparam int EXP_MAX = 255; // infinity or nan.

    localparam logic [31:0] CANON_NAN = 32'h7fc0_0000;

    localparam logic [4:0] OP_ADD = 5'd16;
    localparam logic [4:0] OP_SUB = 5'd17;
    localparam logic [4:0] OP_MUL = 5'd18;
    localparam logic [4:0] OP_NOP = 5'd22;
    localparam logic [4:0] OP_SLT = 5'd23;

    // one word, read either as a float or as raw bits.
    typedef union packed {
        struct packed {
            logic              sign;
            logic [7:0]        exp;
            logic [FRAC_W-1:0] frac;
        } fields;
        logic [31:0] bits;
    } fp_word_u;

endpackage

// ==== fp_op_ctrl.sv ====
`timescale 1ns/100ps

module fp_op_ctrl (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             req,
    input  logic [31:0]      input_a,
    input  logic [31:0]      input_b,
    input  logic [4:0]       operation,
    input  logic             add_done,
    input  logic             mul_done,
    input  fp_pkg::fp_word_u sel_word,
    input  logic             sel_invalid,
    input  logic             sel_inexact,
    input  logic             sel_underflow,
    input  logic             sel_overflow,
    output logic             ack,
    output logic [31:0]      result,
    output logic             invalid,
    output logic             inexact,
    output logic             underflow,
    output logic             overflow,
    output logic             start_add,
    output logic             start_mul,
    output fp_pkg::fp_word_u op_a,
    output fp_pkg::fp_word_u op_b,
    output logic [4:0]       op_code,
    output logic             op_special
);

    localparam logic [1:0] S_IDLE = 2'd0;
    localparam logic [1:0] S_DISP = 2'd1; // operands held, unit chosen.
    localparam logic [1:0] S_WAIT = 2'd2;
    localparam logic [1:0] S_ACK  = 2'd3;

    logic [1:0] state;
    logic       is_add, is_mul, take;

    // subnormals become a zero of the same sign.
    function automatic fp_pkg::fp_word_u flush(input logic [31:0] w);
        fp_pkg::fp_word_u f;
        f.bits = w;
        if (f.fields.exp == 8'd0)
            f.bits = {w[31], 31'd0};
        return f;
    endfunction

    assign is_add = (op_code == fp_pkg::OP_ADD || op_code == fp_pkg::OP_SUB) && !op_special;
    assign is_mul = (op_code == fp_pkg::OP_MUL) && !op_special;
    assign start_add = (state == S_DISP) && is_add;
    assign start_mul = (state == S_DISP) && is_mul;
    assign take = (state == S_DISP && !is_add && !is_mul) ||
                  (state == S_WAIT && (add_done || mul_done));

    always_ff @(posedge clk) begin
        if (state == S_IDLE && req) begin
            op_a       <= flush(input_a);
            op_b       <= flush(input_b);
            op_code    <= operation;
            op_special <= input_a[30:23] == 8'(fp_pkg::EXP_MAX) ||
                          input_b[30:23] == 8'(fp_pkg::EXP_MAX);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= S_IDLE;
            ack       <= 1'b0;
            result    <= 32'd0;
            invalid   <= 1'b0;
            inexact   <= 1'b0;
            underflow <= 1'b0;
            overflow  <= 1'b0;
        end else begin
            case (state)
                S_IDLE: if (req) state <= S_DISP;
                S_DISP: if (is_add || is_mul) state <= S_WAIT;
                S_ACK: begin
                    if (!req) begin
                        ack   <= 1'b0;
                        state <= S_IDLE;
                    end
                end
                default: ;
            endcase
            if (take) begin
                result    <= sel_word.bits;
                invalid   <= sel_invalid;
                inexact   <= sel_inexact;
                underflow <= sel_underflow;
                overflow  <= sel_overflow;
                ack       <= 1'b1;
                state     <= S_ACK;
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) $rose(ack) |-> req);
    // a start lasts one cycle.
    assert property (@(posedge clk) disable iff (!rst_n)
        (start_add || start_mul) |=> !(start_add || start_mul));

endmodule

// ==== fp_add_sub.sv ====
`timescale 1ns/100ps

module fp_add_sub #(
    parameter int ALIGN_STEP = 1
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             start_add,
    input  fp_pkg::fp_word_u op_a,
    input  fp_pkg::fp_word_u op_b,
    input  logic [4:0]       op_code,
    output logic             add_done,
    output fp_pkg::fp_word_u add_word,
    output logic             add_inexact,
    output logic             add_underflow,
    output logic             add_overflow
);

    localparam int MW = fp_pkg::MANT_W;
    localparam int FW = fp_pkg::FRAC_W;
    localparam logic [1:0] S_IDLE  = 2'd0;
    localparam logic [1:0] S_ALIGN = 2'd1;
    localparam logic [1:0] S_ADD   = 2'd2;
    localparam logic [1:0] S_NORM  = 2'd3;

    logic [1:0]    state;
    logic          sign_a, sign_b, sign_r;
    logic [7:0]    exp_a, exp_b;
    logic [MW-1:0] mant_a, mant_b;
    logic [MW:0]   mant_r;

    logic          sign_b_eff, sum_sign, a_ge_b;
    logic [7:0]    exp_diff;
    logic [2:0]    align_sh, norm_sh;
    logic [MW-1:0] small_mant, lost_mask;
    logic [MW:0]   mag_sum;

    always_comb begin
        sign_b_eff = op_b.fields.sign ^ (op_code == fp_pkg::OP_SUB);
        exp_diff   = (exp_a > exp_b) ? exp_a - exp_b : exp_b - exp_a;
        align_sh   = (exp_diff >= 8'(ALIGN_STEP)) ? 3'(ALIGN_STEP) : exp_diff[2:0];
        small_mant = (exp_a > exp_b) ? mant_b : mant_a;
        lost_mask  = (MW'(1) << align_sh) - MW'(1); // bits shifted out this cycle.
        a_ge_b     = mant_a >= mant_b;
        sum_sign   = (sign_a == sign_b || a_ge_b) ? sign_a : sign_b;
        if (sign_a == sign_b)
            mag_sum = {1'b0, mant_a} + {1'b0, mant_b};
        else if (a_ge_b)
            mag_sum = {1'b0, mant_a - mant_b};
        else
            mag_sum = {1'b0, mant_b - mant_a};
        // leading zeros, capped at one step.
        norm_sh = 3'd0;
        for (int i = 0; i < ALIGN_STEP; i++) begin
            if (!mant_r[MW-1-i] && norm_sh == 3'(i))
                norm_sh = 3'(i + 1);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= S_IDLE;
            add_done <= 1'b0;
        end else begin
            add_done <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (start_add) begin
                        add_inexact   <= 1'b0;
                        add_underflow <= 1'b0;
                        add_overflow  <= 1'b0;
                        if (op_b.bits[30:0] == 31'd0) begin
                            add_word <= op_a;
                            add_done <= 1'b1;
                        end else if (op_a.bits[30:0] == 31'd0) begin
                            add_word.bits <= {sign_b_eff, op_b.bits[30:0]};
                            add_done      <= 1'b1;
                        end else begin
                            sign_a <= op_a.fields.sign;
                            sign_b <= sign_b_eff;
                            exp_a  <= op_a.fields.exp;
                            exp_b  <= op_b.fields.exp;
                            mant_a <= {1'b1, op_a.fields.frac};
                            mant_b <= {1'b1, op_b.fields.frac};
                            state  <= S_ALIGN;
                        end
                    end
                end
                S_ALIGN: begin
                    add_inexact <= add_inexact | (|(small_mant & lost_mask));
                    if (exp_diff == 8'd0) begin
                        state <= S_ADD;
                    end else if (exp_a > exp_b) begin
                        mant_b <= mant_b >> align_sh;
                        exp_b  <= exp_b + 8'(align_sh);
                    end else begin
                        mant_a <= mant_a >> align_sh;
                        exp_a  <= exp_a + 8'(align_sh);
                    end
                end
                S_ADD: begin
                    sign_r <= sum_sign;
                    if (mag_sum == '0) begin
                        add_word.bits <= 32'd0; // exact cancellation.
                        add_done      <= 1'b1;
                        state         <= S_IDLE;
                    end else if (mag_sum[MW]) begin
                        add_inexact <= add_inexact | mag_sum[0];
                        if (exp_a == 8'(fp_pkg::EXP_MAX - 1)) begin
                            add_word.bits <= {sum_sign, 8'hff, FW'(0)};
                            add_overflow  <= 1'b1;
                            add_done      <= 1'b1;
                            state         <= S_IDLE;
                        end else begin
                            mant_r <= mag_sum >> 1;
                            exp_a  <= exp_a + 8'd1;
                            state  <= S_NORM;
                        end
                    end else begin
                        mant_r <= mag_sum;
                        state  <= S_NORM;
                    end
                end
                S_NORM: begin
                    if (mant_r[MW-1]) begin
                        add_word.bits <= {sign_r, exp_a, mant_r[FW-1:0]};
                        add_done      <= 1'b1;
                        state         <= S_IDLE;
                    end else if (exp_a <= 8'(norm_sh)) begin
                        add_word.bits <= {sign_r, 31'd0};
                        add_underflow <= 1'b1;
                        add_done      <= 1'b1;
                        state         <= S_IDLE;
                    end else begin
                        mant_r <= mant_r << norm_sh;
                        exp_a  <= exp_a - 8'(norm_sh);
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // no subnormal leaves the unit, and infinity only comes with overflow.
    assert property (@(posedge clk) disable iff (!rst_n)
        add_done |-> (add_word.fields.exp != 8'd0 || add_word.fields.frac == '0) &&
                     (add_word.fields.exp != 8'hff || add_overflow));

endmodule

// ==== fp_mul.sv ====
`timescale 1ns/100ps

module fp_mul (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             start_mul,
    input  fp_pkg::fp_word_u op_a,
    input  fp_pkg::fp_word_u op_b,
    output logic             mul_done,
    output fp_pkg::fp_word_u mul_word,
    output logic             mul_inexact,
    output logic             mul_underflow,
    output logic             mul_overflow
);

    localparam int MW = fp_pkg::MANT_W;
    localparam int FW = fp_pkg::FRAC_W;

    logic            busy;
    logic            prod_sign, prod_zero;
    logic [2*MW-1:0] prod;
    logic [9:0]      exp_sum; // biased twice.
    logic [9:0]      exp_norm;
    logic [FW-1:0]   frac_r;
    logic            lost;

    always_comb begin
        exp_norm = exp_sum + 10'(prod[2*MW-1]);
        if (prod[2*MW-1]) begin
            frac_r = prod[2*MW-2 -: FW];
            lost   = |prod[MW-1:0];
        end else begin
            frac_r = prod[2*MW-3 -: FW];
            lost   = |prod[MW-2:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            mul_done <= 1'b0;
        end else begin
            busy     <= start_mul;
            mul_done <= busy;
        end
    end

    always_ff @(posedge clk) begin
        if (start_mul) begin
            prod      <= (2*MW)'({1'b1, op_a.fields.frac}) * (2*MW)'({1'b1, op_b.fields.frac});
            exp_sum   <= 10'(op_a.fields.exp) + 10'(op_b.fields.exp);
            prod_sign <= op_a.fields.sign ^ op_b.fields.sign;
            prod_zero <= op_a.bits[30:0] == 31'd0 || op_b.bits[30:0] == 31'd0;
        end
        if (busy) begin
            mul_inexact   <= !prod_zero && lost;
            mul_underflow <= 1'b0;
            mul_overflow  <= 1'b0;
            if (prod_zero) begin
                mul_word.bits <= 32'd0;
            end else if (exp_norm >= 10'(fp_pkg::EXP_MAX + fp_pkg::EXP_BIAS)) begin
                mul_word.bits <= {prod_sign, 8'hff, FW'(0)};
                mul_overflow  <= 1'b1;
            end else if (exp_norm <= 10'(fp_pkg::EXP_BIAS)) begin
                mul_word.bits <= {prod_sign, 31'd0};
                mul_underflow <= 1'b1;
            end else begin
                mul_word.bits <= {prod_sign, 8'(exp_norm - 10'(fp_pkg::EXP_BIAS)), frac_r};
            end
        end
    end

endmodule

// ==== fp_result_sel.sv ====
`timescale 1ns/100ps

module fp_result_sel (
    input  fp_pkg::fp_word_u op_a,
    input  fp_pkg::fp_word_u op_b,
    input  logic [4:0]       op_code,
    input  logic             op_special,
    input  fp_pkg::fp_word_u add_word,
    input  logic             add_inexact,
    input  logic             add_underflow,
    input  logic             add_overflow,
    input  fp_pkg::fp_word_u mul_word,
    input  logic             mul_inexact,
    input  logic             mul_underflow,
    input  logic             mul_overflow,
    output fp_pkg::fp_word_u sel_word,
    output logic             sel_invalid,
    output logic             sel_inexact,
    output logic             sel_underflow,
    output logic             sel_overflow
);

    logic slt;

    always_comb begin
        // sign first, magnitude order flips for negatives.
        if (op_a.fields.sign != op_b.fields.sign)
            slt = op_a.fields.sign;
        else if (op_a.fields.sign)
            slt = op_a.bits[30:0] > op_b.bits[30:0];
        else
            slt = op_a.bits[30:0] < op_b.bits[30:0];

        sel_word      = op_a; // nop and unknown codes.
        sel_invalid   = 1'b0;
        sel_inexact   = 1'b0;
        sel_underflow = 1'b0;
        sel_overflow  = 1'b0;
        case (op_code)
            fp_pkg::OP_ADD, fp_pkg::OP_SUB: begin
                sel_word      = add_word;
                sel_inexact   = add_inexact;
                sel_underflow = add_underflow;
                sel_overflow  = add_overflow;
            end
            fp_pkg::OP_MUL: begin
                sel_word      = mul_word;
                sel_inexact   = mul_inexact;
                sel_underflow = mul_underflow;
                sel_overflow  = mul_overflow;
            end
            fp_pkg::OP_SLT: sel_word.bits = {31'd0, slt};
            default: ;
        endcase

        if (op_special && op_code inside {fp_pkg::OP_ADD, fp_pkg::OP_SUB,
                                          fp_pkg::OP_MUL, fp_pkg::OP_SLT}) begin
            sel_word.bits = fp_pkg::CANON_NAN;
            sel_invalid   = 1'b1;
            sel_inexact   = 1'b0;
            sel_underflow = 1'b0;
            sel_overflow  = 1'b0;
        end
    end

endmodule

// ==== fp_alu_top.sv ====
`timescale 1ns/100ps

module fp_alu_top #(
    parameter int ALIGN_STEP = 1
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        req,
    input  logic [31:0] input_a,
    input  logic [31:0] input_b,
    input  logic [4:0]  operation,
    output logic        ack,
    output logic [31:0] result,
    output logic        invalid,
    output logic        inexact,
    output logic        underflow,
    output logic        overflow
);

    fp_pkg::fp_word_u op_a, op_b;
    fp_pkg::fp_word_u add_word, mul_word, sel_word;
    logic [4:0] op_code;
    logic       op_special;
    logic       start_add, start_mul;
    logic       add_done, add_inexact, add_underflow, add_overflow;
    logic       mul_done, mul_inexact, mul_underflow, mul_overflow;
    logic       sel_invalid, sel_inexact, sel_underflow, sel_overflow;

    fp_op_ctrl u_ctrl (
        .clk(clk), .rst_n(rst_n), .req(req),
        .input_a(input_a), .input_b(input_b), .operation(operation),
        .add_done(add_done), .mul_done(mul_done),
        .sel_word(sel_word), .sel_invalid(sel_invalid), .sel_inexact(sel_inexact),
        .sel_underflow(sel_underflow), .sel_overflow(sel_overflow),
        .ack(ack), .result(result), .invalid(invalid), .inexact(inexact),
        .underflow(underflow), .overflow(overflow),
        .start_add(start_add), .start_mul(start_mul),
        .op_a(op_a), .op_b(op_b), .op_code(op_code), .op_special(op_special)
    );

    fp_add_sub #(
        .ALIGN_STEP(ALIGN_STEP)
    ) u_add_sub (
        .clk(clk), .rst_n(rst_n), .start_add(start_add),
        .op_a(op_a), .op_b(op_b), .op_code(op_code),
        .add_done(add_done), .add_word(add_word), .add_inexact(add_inexact),
        .add_underflow(add_underflow), .add_overflow(add_overflow)
    );

    fp_mul u_mul (
        .clk(clk), .rst_n(rst_n), .start_mul(start_mul),
        .op_a(op_a), .op_b(op_b),
        .mul_done(mul_done), .mul_word(mul_word), .mul_inexact(mul_inexact),
        .mul_underflow(mul_underflow), .mul_overflow(mul_overflow)
    );

    fp_result_sel u_sel (
        .op_a(op_a), .op_b(op_b), .op_code(op_code), .op_special(op_special),
        .add_word(add_word), .add_inexact(add_inexact),
        .add_underflow(add_underflow), .add_overflow(add_overflow),
        .mul_word(mul_word), .mul_inexact(mul_inexact),
        .mul_underflow(mul_underflow), .mul_overflow(mul_overflow),
        .sel_word(sel_word), .sel_invalid(sel_invalid), .sel_inexact(sel_inexact),
        .sel_underflow(sel_underflow), .sel_overflow(sel_overflow)
    );

endmodule

// ==== tb_fp_ref.svh ====
`ifndef TB_FP_REF_SVH
`define TB_FP_REF_SVH

// expected {word, invalid, inexact, underflow, overflow} of one request.
function automatic logic [35:0] fp_reference(input logic [31:0] a_in, input logic [31:0] b_in,
                                             input logic [4:0] op);
    logic [31:0] a, b, w;
    logic        inx, unf, ovf, sb, sr, lt, gt;
    logic [23:0] ma, mb, sm;
    logic [24:0] mag;
    logic [47:0] prod;
    int          ea, eb, er, diff, lz;
    a   = (a_in[30:23] == 8'd0) ? {a_in[31], 31'd0} : a_in; // subnormal to signed zero.
    b   = (b_in[30:23] == 8'd0) ? {b_in[31], 31'd0} : b_in;
    w   = a;
    inx = 1'b0;
    unf = 1'b0;
    ovf = 1'b0;
    if ((a_in[30:23] == 8'hff || b_in[30:23] == 8'hff) &&
        op inside {fp_pkg::OP_ADD, fp_pkg::OP_SUB, fp_pkg::OP_MUL, fp_pkg::OP_SLT})
        return {32'h7fc0_0000, 4'b1000};
    case (op)
        fp_pkg::OP_ADD, fp_pkg::OP_SUB: begin
            sb = b[31] ^ (op == fp_pkg::OP_SUB);
            if (b[30:0] == 31'd0) begin
                w = a;
            end else if (a[30:0] == 31'd0) begin
                w = {sb, b[30:0]};
            end else begin
                ea   = int'(a[30:23]);
                eb   = int'(b[30:23]);
                ma   = {1'b1, a[22:0]};
                mb   = {1'b1, b[22:0]};
                er   = (ea >= eb) ? ea : eb;
                diff = (ea >= eb) ? ea - eb : eb - ea;
                sm   = (ea >= eb) ? mb : ma; // the one that gets shifted.
                if (diff >= 24) begin
                    inx = 1'b1;
                    sm  = 24'd0;
                end else begin
                    inx = (sm & ((24'd1 << diff) - 24'd1)) != 24'd0;
                    sm  = sm >> diff;
                end
                if (ea >= eb)
                    mb = sm;
                else
                    ma = sm;
                sr = (a[31] == sb || ma >= mb) ? a[31] : sb;
                if (a[31] == sb)
                    mag = {1'b0, ma} + {1'b0, mb};
                else if (ma >= mb)
                    mag = {1'b0, ma - mb};
                else
                    mag = {1'b0, mb - ma};
                if (mag == 25'd0) begin
                    w = 32'd0;
                end else if (mag[24]) begin
                    inx = inx | mag[0];
                    if (er == 254) begin
                        w   = {sr, 8'hff, 23'd0};
                        ovf = 1'b1;
                    end else begin
                        w = {sr, 8'(er + 1), mag[23:1]};
                    end
                end else begin
                    lz = 0;
                    while (!mag[23 - lz])
                        lz = lz + 1;
                    mag = mag << lz;
                    if (er - lz < 1) begin
                        w   = {sr, 31'd0};
                        unf = 1'b1;
                    end else begin
                        w = {sr, 8'(er - lz), mag[22:0]};
                    end
                end
            end
        end
        fp_pkg::OP_MUL: begin
            if (a[30:0] == 31'd0 || b[30:0] == 31'd0) begin
                w = 32'd0;
            end else begin
                prod = 48'({1'b1, a[22:0]}) * 48'({1'b1, b[22:0]});
                er   = int'(a[30:23]) + int'(b[30:23]) - 127;
                if (prod[47]) begin
                    er  = er + 1;
                    inx = |prod[23:0];
                    w   = {a[31] ^ b[31], 8'(er), prod[46:24]};
                end else begin
                    inx = |prod[22:0];
                    w   = {a[31] ^ b[31], 8'(er), prod[45:23]};
                end
                if (er >= 255) begin
                    w   = {a[31] ^ b[31], 8'hff, 23'd0};
                    ovf = 1'b1;
                end else if (er <= 0) begin
                    w   = {a[31] ^ b[31], 31'd0};
                    unf = 1'b1;
                end
            end
        end
        fp_pkg::OP_SLT: begin
            // magnitudes order by exponent first and fraction after.
            if (a[30:23] != b[30:23])
                lt = a[30:23] < b[30:23];
            else
                lt = a[22:0] < b[22:0];
            gt = (a[30:0] != b[30:0]) && !lt;
            if (a[31] != b[31])
                w = {31'd0, a[31]}; // any negative is below any positive, -0 too.
            else
                w = {31'd0, a[31] ? gt : lt};
        end
        default: w = a;
    endcase
    return {w, 1'b0, inx, unf, ovf};
endfunction

`endif

// ==== tb_fp_alu.sv ====
`timescale 1ns/100ps

module tb_fp_alu;

    localparam int ACK_TIMEOUT = 1000; // cycles, above the longest alignment.
    localparam int RANDOM_OPS  = 400;

    logic        clk;
    logic        rst_n;
    logic        req;
    logic [31:0] input_a;
    logic [31:0] input_b;
    logic [4:0]  operation;
    logic        ack;
    logic [31:0] result;
    logic        invalid, inexact, underflow, overflow;

    logic [31:0] lfsr = 32'h65ff_f3fe;
    logic [35:0] expect_q[$];
    int          issued = 0;
    int          checked = 0;

    `include "tb_fp_ref.svh"

    fp_alu_top #(
        .ALIGN_STEP(1)
    ) u_dut (
        .clk(clk), .rst_n(rst_n), .req(req),
        .input_a(input_a), .input_b(input_b), .operation(operation),
        .ack(ack), .result(result), .invalid(invalid), .inexact(inexact),
        .underflow(underflow), .overflow(overflow)
    );

    always #50 clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1, "run stopped");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] want);
        $display("error: %s is %h, expected %h", name, got, want);
        abort_run("stopping at the first wrong value");
    endtask

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'ha300_0000) : (s >> 1); // taps 32 30 26 25.
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = 32'd0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
        return v;
    endfunction

    function automatic logic [31:0] special_operand(input logic [2:0] k);
        case (k)
            3'd0: return 32'h0000_0000;
            3'd1: return 32'h8000_0000;
            3'd2: return 32'h0000_0001; // subnormal.
            3'd3: return 32'h807f_ffff;
            3'd4: return 32'h7f80_0000;
            3'd5: return 32'hff80_0000;
            3'd6: return 32'h7fc0_0000;
            default: return 32'h7f81_2345;
        endcase
    endfunction

    function automatic logic [31:0] random_operand();
        logic [7:0] e;
        if (rand_bits(4) == 32'd0)
            return special_operand(3'(rand_bits(3)));
        e = 8'(100 + rand_bits(6) % 55);
        return {rand_bits(1) == 32'd1, e, 23'(rand_bits(23))};
    endfunction

    // one full four-phase transfer, holding req for a few random extra cycles.
    task automatic run_op(input logic [31:0] a, input logic [31:0] b, input logic [4:0] op);
        int          cycles;
        int          hold;
        logic [31:0] held_word;
        logic [3:0]  held_flags;
        expect_q.push_back(fp_reference(a, b, op));
        issued++;
        @(posedge clk);
        #1;
        input_a   = a;
        input_b   = b;
        operation = op;
        req       = 1'b1;
        cycles    = 0;
        while (ack !== 1'b1) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > ACK_TIMEOUT)
                abort_run("timed out waiting for ack to rise");
        end
        held_word  = result;
        held_flags = {invalid, inexact, underflow, overflow};
        hold       = 1 + int'(rand_bits(3));
        repeat (hold) begin
            @(posedge clk);
            #1;
            assert (ack === 1'b1) else abort_run("ack dropped while req was still high");
            assert (result === held_word) else report_mismatch("result", result, held_word);
            assert ({invalid, inexact, underflow, overflow} === held_flags)
                else report_mismatch("flags", 32'({invalid, inexact, underflow, overflow}),
                                     32'(held_flags));
        end
        req    = 1'b0;
        cycles = 0;
        while (ack !== 1'b0) begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > ACK_TIMEOUT)
                abort_run("timed out waiting for ack to fall");
        end
    endtask

    always @(posedge ack) begin
        logic [35:0] expected;
        #2;
        assert (req === 1'b1) else abort_run("ack rose while req was low");
        assert (expect_q.size() > 0) else abort_run("ack rose with no request pending");
        expected = expect_q.pop_front();
        assert (result === expected[35:4]) else report_mismatch("result", result, expected[35:4]);
        assert (invalid === expected[3])
            else report_mismatch("invalid", 32'(invalid), 32'(expected[3]));
        assert (inexact === expected[2])
            else report_mismatch("inexact", 32'(inexact), 32'(expected[2]));
        assert (underflow === expected[1])
            else report_mismatch("underflow", 32'(underflow), 32'(expected[1]));
        assert (overflow === expected[0])
            else report_mismatch("overflow", 32'(overflow), 32'(expected[0]));
        checked++;
    end

    initial begin
        logic [31:0] a, b, pick;
        logic [4:0]  op;
        clk       = 1'b0;
        rst_n     = 1'b0;
        req       = 1'b0;
        input_a   = 32'd0;
        input_b   = 32'd0;
        operation = 5'd0;
        repeat (16) @(posedge clk);
        #1;
        assert (ack === 1'b0) else report_mismatch("ack", 32'(ack), 32'd0);
        assert (result === 32'd0) else report_mismatch("result", result, 32'd0);
        assert ({invalid, inexact, underflow, overflow} === 4'd0)
            else report_mismatch("flags", 32'({invalid, inexact, underflow, overflow}), 32'd0);
        rst_n = 1'b1;

        run_op(32'h3f80_0000, 32'h4000_0000, fp_pkg::OP_NOP);
        run_op(32'h7f81_2345, 32'h0000_0000, fp_pkg::OP_NOP); // nan passes untouched.
        run_op(32'h1234_5678, 32'h3f80_0000, 5'd3);
        run_op(32'h8000_0000, 32'h0000_0000, fp_pkg::OP_SLT);
        run_op(32'h0000_0000, 32'h8000_0000, fp_pkg::OP_SLT);
        run_op(32'h4040_0000, 32'h4040_0000, fp_pkg::OP_SLT);
        run_op(32'hc040_0000, 32'hc000_0000, fp_pkg::OP_SLT);
        run_op(32'h0000_0001, 32'h0000_0000, fp_pkg::OP_SLT);
        run_op(32'h0000_0000, 32'h3f80_0000, fp_pkg::OP_SUB);
        run_op(32'hc0a0_0000, 32'h8000_0000, fp_pkg::OP_ADD);
        run_op(32'h3f80_0000, 32'h3f80_0000, fp_pkg::OP_SUB); // exact cancellation.
        run_op(32'h0000_0001, 32'h3f80_0000, fp_pkg::OP_ADD);
        run_op(32'h8000_0000, 32'h4120_0000, fp_pkg::OP_MUL);
        run_op(32'h7f7f_ffff, 32'h7f7f_ffff, fp_pkg::OP_ADD);
        run_op(32'hff7f_ffff, 32'hff00_0000, fp_pkg::OP_ADD);
        run_op(32'h00c0_0000, 32'h8080_0000, fp_pkg::OP_ADD);
        run_op(32'h7f00_0000, 32'hc080_0000, fp_pkg::OP_MUL);
        run_op(32'h0080_0000, 32'h3f00_0000, fp_pkg::OP_MUL);
        run_op(32'h3f80_0000, 32'h0080_0001, fp_pkg::OP_ADD); // gap of 126.
        run_op(32'h7f80_0000, 32'h3f80_0000, fp_pkg::OP_ADD);
        run_op(32'h3f80_0000, 32'hff80_0001, fp_pkg::OP_SUB);
        run_op(32'h7f80_0000, 32'h0000_0000, fp_pkg::OP_MUL);
        run_op(32'h7fc0_0000, 32'h3f80_0000, fp_pkg::OP_SLT);

        for (int n = 0; n < RANDOM_OPS; n++) begin
            a    = random_operand();
            b    = random_operand();
            pick = rand_bits(3);
            case (pick)
                32'd0, 32'd1: op = fp_pkg::OP_ADD;
                32'd2, 32'd3: op = fp_pkg::OP_SUB;
                32'd4, 32'd5: op = fp_pkg::OP_MUL;
                32'd6:        op = fp_pkg::OP_SLT;
                default:      op = (rand_bits(1) == 32'd1) ? fp_pkg::OP_NOP : 5'd5;
            endcase
            if (op == fp_pkg::OP_ADD || op == fp_pkg::OP_SUB) begin
                pick = rand_bits(2);
                if (pick == 32'd0)
                    b[30:23] = a[30:23];
                else if (pick == 32'd1)
                    b = {a[31] ^ (op == fp_pkg::OP_ADD), a[30:0] ^ 31'(rand_bits(6))};
            end
            run_op(a, b, op);
        end

        if (expect_q.size() != 0 || checked != issued) begin
            abort_run("not every request got an answer");
        end else begin
            $display("Everything OK");
            $finish;
        end
    end

endmodule

// ==== filelist.f ====
+incdir+.
fp_pkg.sv
fp_op_ctrl.sv
fp_add_sub.sv
fp_mul.sv
fp_result_sel.sv
fp_alu_top.sv
tb_fp_alu.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    -f filelist.f \
    --top-module tb_fp_alu \
    -o tb_fp_alu_sim

./obj_dir/tb_fp_alu_sim
